// File: common/mem_bus_pkg.sv
package mem_bus_pkg;

   // ----------------------------------------------------------
   // Bus widths and memory size
   // ----------------------------------------------------------

   localparam int addr_w    = 8;    // Word address
   localparam int data_w    = 32;
   localparam int mem_depth = 192;  // Implemented words, the rest of the map errors

   // ----------------------------------------------------------
   // Channel payloads
   // ----------------------------------------------------------

   // Request channel, master to memory
   typedef struct packed {
      logic              we;     // 1 = write, 0 = read
      logic [addr_w-1:0] addr;
      logic [data_w-1:0] wdata;  // Ignored on reads
   } mem_req_t;

   // Response channel, memory to master
   // Writes return one too, with rdata zero
   typedef struct packed {
      logic [data_w-1:0] rdata;
      logic              err;    // Address out of range
   } mem_rsp_t;

endpackage

// File: common/system_pkg.sv
package system_pkg;

   // Tester and unit under test
   localparam int n_masters = 2;

   // Memory init time after reset release, in clk cycles
   localparam int mem_init_cycles = 20;

   // Width of the init counter, holds mem_init_cycles itself
   localparam int init_cnt_w = $clog2(mem_init_cycles + 1);

   // Reset release flops
   localparam int sync_stages = 2;

   typedef logic [$clog2(n_masters)-1:0] master_idx_t;

endpackage

// File: logic/reset_sync.sv
`timescale 1ns/1ps

module reset_sync (
   input  logic clk,
   input  logic arst_n,
   input  logic init_done,
   output logic rst
);

   logic [system_pkg::sync_stages-1:0] sync_q;

   // Set at once by arst_n, drained by zeros once memory is ready
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         sync_q <= '1;
      end else begin
         sync_q <= {sync_q[system_pkg::sync_stages-2:0], ~init_done};
      end
   end

   assign rst = sync_q[system_pkg::sync_stages-1];  // Last stage

   // ----------------------------------------------------------
   // Checks
   // ----------------------------------------------------------

   // Release only after init_done has passed the whole chain
   a_rst_after_init: assert property (
      @(posedge clk) disable iff (!arst_n)
      $fell(rst) |-> $past(init_done, system_pkg::sync_stages)
   );

endmodule

// File: memory/mem_init_timer.sv
`timescale 1ns/1ps

module mem_init_timer (
   input  logic clk,
   input  logic arst_n,
   output logic init_done
);

   // Stand-in for the memory controller calibration time

   logic [system_pkg::init_cnt_w-1:0] cnt_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         cnt_q <= '0;
      end else if (!init_done) begin
         cnt_q <= cnt_q + 1'b1;  // Saturates at the terminal count
      end
   end

   // Terminal count reached
   assign init_done =
      (cnt_q == system_pkg::init_cnt_w'(system_pkg::mem_init_cycles));

endmodule

// File: memory/mem_model.sv
`timescale 1ns/1ps

module mem_model (
   input  logic                  clk,
   input  logic                  arst_n,
   input  logic                  rst,
   input  mem_bus_pkg::mem_req_t req,
   input  logic                  req_valid,
   output logic                  req_ready,
   output mem_bus_pkg::mem_rsp_t rsp,
   output logic                  rsp_valid,
   input  logic                  rsp_ready
);

   logic [mem_bus_pkg::data_w-1:0] mem [mem_bus_pkg::mem_depth];
   logic [mem_bus_pkg::mem_depth-1:0] written_q;  // Word holds stored data
   mem_bus_pkg::mem_rsp_t rsp_q;
   logic rsp_valid_q;
   logic req_fire;
   logic in_range;

   assign req_ready = !rsp_valid_q;  // One transaction at a time
   assign req_fire  = req_valid && req_ready;
   assign in_range  = (req.addr < mem_bus_pkg::mem_depth);

   // ----------------------------------------------------------
   // Control
   // ----------------------------------------------------------

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         rsp_valid_q <= 1'b0;
         written_q   <= '0;
      end else if (rst) begin
         rsp_valid_q <= 1'b0;
         written_q   <= '0;  // Reads as zero again after reset
      end else begin
         if (req_fire) begin
            rsp_valid_q <= 1'b1;
         end else if (rsp_ready) begin
            rsp_valid_q <= 1'b0;
         end
         if (req_fire && req.we && in_range) begin
            written_q[req.addr] <= 1'b1;
         end
      end
   end

   // ----------------------------------------------------------
   // Array and response data
   // ----------------------------------------------------------

   always_ff @(posedge clk) begin
      if (req_fire) begin
         if (req.we && in_range) begin
            mem[req.addr] <= req.wdata;
         end
         rsp_q.rdata <= (!req.we && in_range && written_q[req.addr]) ? mem[req.addr] : '0;
         rsp_q.err   <= !in_range;
      end
   end

   assign rsp       = rsp_q;
   assign rsp_valid = rsp_valid_q;

   a_rsp_hold: assert property (
      @(posedge clk) disable iff (!arst_n || rst)
      rsp_valid && !rsp_ready |=> rsp_valid && $stable(rsp)
   );

endmodule

// File: logic/pipe_reg.sv
`timescale 1ns/1ps

module pipe_reg #(
   parameter type payload_t = logic [31:0]
) (
   input  logic     clk,
   input  logic     arst_n,
   input  logic     rst,
   input  payload_t in_data,
   input  logic     in_valid,
   output logic     in_ready,
   output payload_t out_data,
   output logic     out_valid,
   input  logic     out_ready
);

   payload_t main_q;   // Output stage
   payload_t spare_q;  // Skid entry, used while downstream stalls
   logic main_valid_q, spare_valid_q, ready_q;
   logic main_valid_n, spare_valid_n;
   logic in_fire, out_fire;
   logic load_in, load_spare, move_spare;

   assign in_fire  = in_valid && ready_q;
   assign out_fire = main_valid_q && out_ready;

   always_comb begin
      main_valid_n  = main_valid_q;
      spare_valid_n = spare_valid_q;
      load_in       = 1'b0;
      load_spare    = 1'b0;
      move_spare    = 1'b0;
      if (!main_valid_q || out_fire) begin
         if (spare_valid_q) begin  // Older item goes first
            move_spare    = 1'b1;
            main_valid_n  = 1'b1;
            spare_valid_n = 1'b0;
         end else begin
            load_in      = in_fire;
            main_valid_n = in_fire;
         end
      end else if (in_fire) begin
         load_spare    = 1'b1;
         spare_valid_n = 1'b1;
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         main_valid_q  <= 1'b0;
         spare_valid_q <= 1'b0;
         ready_q       <= 1'b0;
      end else if (rst) begin
         main_valid_q  <= 1'b0;
         spare_valid_q <= 1'b0;
         ready_q       <= 1'b0;
      end else begin
         main_valid_q  <= main_valid_n;
         spare_valid_q <= spare_valid_n;
         ready_q       <= !spare_valid_n;  // Drops only when both are full
      end
   end

   always_ff @(posedge clk) begin
      if (move_spare) begin
         main_q <= spare_q;
      end else if (load_in) begin
         main_q <= in_data;
      end
      if (load_spare) begin
         spare_q <= in_data;
      end
   end

   assign in_ready  = ready_q;
   assign out_data  = main_q;
   assign out_valid = main_valid_q;

endmodule

// File: logic/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
   input  logic                                              clk,
   input  logic                                              arst_n,
   input  logic                                              rst,
   input  mem_bus_pkg::mem_req_t [system_pkg::n_masters-1:0] req,
   input  logic [system_pkg::n_masters-1:0]                  req_valid,
   output logic [system_pkg::n_masters-1:0]                  req_ready,
   output mem_bus_pkg::mem_rsp_t [system_pkg::n_masters-1:0] rsp,
   output logic [system_pkg::n_masters-1:0]                  rsp_valid,
   input  logic [system_pkg::n_masters-1:0]                  rsp_ready,
   output mem_bus_pkg::mem_req_t                             mem_req,
   output logic                                              mem_req_valid,
   input  logic                                              mem_req_ready,
   input  mem_bus_pkg::mem_rsp_t                             mem_rsp,
   input  logic                                              mem_rsp_valid,
   output logic                                              mem_rsp_ready
);

   typedef enum logic [1:0] {st_idle, st_issue, st_wait} state_t;

   state_t state_q, state_n;
   system_pkg::master_idx_t owner_q;  // Current owner and last winner
   system_pkg::master_idx_t pick;
   logic any_req;

   // ----------------------------------------------------------
   // Round-robin pick starting past the last winner
   // ----------------------------------------------------------

   always_comb begin
      system_pkg::master_idx_t idx;
      pick    = owner_q;
      any_req = 1'b0;
      for (int k = 1; k <= system_pkg::n_masters; k++) begin
         idx = system_pkg::master_idx_t'((int'(owner_q) + k) % system_pkg::n_masters);
         if (!any_req && req_valid[idx]) begin
            pick    = idx;
            any_req = 1'b1;
         end
      end
   end

   always_comb begin
      state_n = state_q;
      case (state_q)
         st_idle:  if (any_req) state_n = st_issue;
         st_issue: if (mem_req_valid && mem_req_ready) state_n = st_wait;
         st_wait:  if (mem_rsp_valid && mem_rsp_ready) state_n = st_idle;  // Owner took it
         default:  state_n = st_idle;
      endcase
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         state_q <= st_idle;
         owner_q <= system_pkg::master_idx_t'(system_pkg::n_masters - 1);  // Master 0 first
      end else if (rst) begin
         state_q <= st_idle;
         owner_q <= system_pkg::master_idx_t'(system_pkg::n_masters - 1);
      end else begin
         state_q <= state_n;
         if (state_q == st_idle && any_req) begin
            owner_q <= pick;
         end
      end
   end

   // ----------------------------------------------------------
   // Routing
   // ----------------------------------------------------------

   assign mem_req       = req[owner_q];
   assign mem_req_valid = (state_q == st_issue) && req_valid[owner_q];
   assign mem_rsp_ready = (state_q == st_wait) && rsp_ready[owner_q];

   always_comb begin
      for (int i = 0; i < system_pkg::n_masters; i++) begin
         req_ready[i] = (state_q == st_issue) && (owner_q == system_pkg::master_idx_t'(i))
                        && mem_req_ready;
         rsp[i]       = mem_rsp;  // Data to all and valid to the owner only
         rsp_valid[i] = (state_q == st_wait) && (owner_q == system_pkg::master_idx_t'(i))
                        && mem_rsp_valid;
      end
   end

   // Grant only to a master whose request is still held
   a_grant_requested: assert property (
      @(posedge clk) disable iff (!arst_n || rst)
      state_q == st_issue |-> req_valid[owner_q]
   );

   // Memory answers only while a transaction is owned
   a_rsp_owned: assert property (
      @(posedge clk) disable iff (!arst_n || rst)
      mem_rsp_valid |-> state_q == st_wait
   );

endmodule

// File: logic/top_system.sv
`timescale 1ns/1ps

module top_system (
   input  logic                                              clk,
   input  logic                                              arst_n,
   input  mem_bus_pkg::mem_req_t [system_pkg::n_masters-1:0] m_req,
   input  logic [system_pkg::n_masters-1:0]                  m_req_valid,
   output logic [system_pkg::n_masters-1:0]                  m_req_ready,
   output mem_bus_pkg::mem_rsp_t [system_pkg::n_masters-1:0] m_rsp,
   output logic [system_pkg::n_masters-1:0]                  m_rsp_valid,
   input  logic [system_pkg::n_masters-1:0]                  m_rsp_ready
);

   logic rst;
   logic init_done;

   mem_bus_pkg::mem_req_t [system_pkg::n_masters-1:0] s_req;  // Slice to arbiter
   logic [system_pkg::n_masters-1:0] s_req_valid, s_req_ready;
   mem_bus_pkg::mem_rsp_t [system_pkg::n_masters-1:0] a_rsp;  // Arbiter to slice
   logic [system_pkg::n_masters-1:0] a_rsp_valid, a_rsp_ready;

   mem_bus_pkg::mem_req_t mem_req;
   logic                  mem_req_valid, mem_req_ready;
   mem_bus_pkg::mem_rsp_t mem_rsp;
   logic                  mem_rsp_valid, mem_rsp_ready;

   // ----------------------------------------------------------
   // Reset, held until memory init is done
   // ----------------------------------------------------------

   mem_init_timer init_timer (.clk, .arst_n, .init_done);

   reset_sync rst_sync (.clk, .arst_n, .init_done, .rst);

   // ----------------------------------------------------------
   // Master port slices
   // ----------------------------------------------------------

   for (genvar m = 0; m < system_pkg::n_masters; m++) begin : g_master
      pipe_reg #(.payload_t(mem_bus_pkg::mem_req_t)) req_slice (
         .clk, .arst_n, .rst,
         .in_data  (m_req[m]), .in_valid (m_req_valid[m]), .in_ready (m_req_ready[m]),
         .out_data (s_req[m]), .out_valid(s_req_valid[m]), .out_ready(s_req_ready[m])
      );
      pipe_reg #(.payload_t(mem_bus_pkg::mem_rsp_t)) rsp_slice (
         .clk, .arst_n, .rst,
         .in_data  (a_rsp[m]), .in_valid (a_rsp_valid[m]), .in_ready (a_rsp_ready[m]),
         .out_data (m_rsp[m]), .out_valid(m_rsp_valid[m]), .out_ready(m_rsp_ready[m])
      );
   end

   bus_arbiter arbiter (
      .clk, .arst_n, .rst,
      .req (s_req), .req_valid (s_req_valid), .req_ready (s_req_ready),
      .rsp (a_rsp), .rsp_valid (a_rsp_valid), .rsp_ready (a_rsp_ready),
      .mem_req, .mem_req_valid, .mem_req_ready,
      .mem_rsp, .mem_rsp_valid, .mem_rsp_ready
   );

   mem_model memory (
      .clk, .arst_n, .rst,
      .req (mem_req), .req_valid (mem_req_valid), .req_ready (mem_req_ready),
      .rsp (mem_rsp), .rsp_valid (mem_rsp_valid), .rsp_ready (mem_rsp_ready)
   );

endmodule

// File: bench/tb_top_system.sv
`timescale 1ns/1ps

module tb_top_system;

   localparam int n_m         = system_pkg::n_masters;
   localparam int half        = mem_bus_pkg::mem_depth / system_pkg::n_masters;
   localparam int min_release = system_pkg::mem_init_cycles + system_pkg::sync_stages;
   localparam int init_limit  = 100;   // Cycles
   localparam int req_limit   = 400;
   localparam int drain_limit = 3000;

   logic clk;
   logic arst_n;
   mem_bus_pkg::mem_req_t [n_m-1:0] m_req;
   logic [n_m-1:0] m_req_valid;
   logic [n_m-1:0] m_req_ready;
   mem_bus_pkg::mem_rsp_t [n_m-1:0] m_rsp;
   logic [n_m-1:0] m_rsp_valid;
   logic [n_m-1:0] m_rsp_ready;

   logic [mem_bus_pkg::data_w-1:0] ref_mem [mem_bus_pkg::mem_depth];
   mem_bus_pkg::mem_rsp_t exp_q [n_m][$];  // Expected responses per master
   logic [31:0] rng;
   int errors;
   int timeouts;
   int rsp_count;
   int n;
   int stall;

   top_system DUT (
      .clk, .arst_n,
      .m_req, .m_req_valid, .m_req_ready,
      .m_rsp, .m_rsp_valid, .m_rsp_ready
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   function automatic logic [31:0] lcg_step(input logic [31:0] s);
      return s * 32'd1664525 + 32'd1013904223;
   endfunction

   // ----------------------------------------------------------
   // Reference memory applied in acceptance order per master
   // ----------------------------------------------------------

   function automatic mem_bus_pkg::mem_rsp_t ref_access(input mem_bus_pkg::mem_req_t r);
      mem_bus_pkg::mem_rsp_t res;
      res.rdata = '0;
      res.err   = (int'(r.addr) >= mem_bus_pkg::mem_depth);
      if (!res.err) begin
         if (r.we)
            ref_mem[r.addr] = r.wdata;
         else
            res.rdata = ref_mem[r.addr];  // Writes answer with zero data
      end
      return res;
   endfunction

   always @(posedge clk) begin
      mem_bus_pkg::mem_rsp_t want;
      for (int m = 0; m < n_m; m++) begin
         if (m_req_valid[m] && m_req_ready[m]) begin
            exp_q[m].push_back(ref_access(m_req[m]));
         end
         if (m_rsp_valid[m] && m_rsp_ready[m]) begin
            if (exp_q[m].size() == 0) begin
               $display("master %0d got a response with no request outstanding at %0t",
                        m, $time);
               errors++;
            end else begin
               want = exp_q[m].pop_front();
               rsp_count++;
               if (m_rsp[m].rdata !== want.rdata) begin
                  $display("ERROR %0t m_rsp[%0d].rdata expected %h actual %h",
                           $time, m, want.rdata, m_rsp[m].rdata);
                  errors++;
               end
               if (m_rsp[m].err !== want.err) begin
                  $display("ERROR %0t m_rsp[%0d].err expected %b actual %b",
                           $time, m, want.err, m_rsp[m].err);
                  errors++;
               end
            end
         end
      end
   end

   // ----------------------------------------------------------
   // Master drivers
   // ----------------------------------------------------------

   // Called on a rising edge and returns on the edge of the transfer
   task automatic send_req(input int m, input logic we,
                           input logic [mem_bus_pkg::addr_w-1:0] addr,
                           input logic [mem_bus_pkg::data_w-1:0] wdata);
      mem_bus_pkg::mem_req_t r;
      int cnt;
      r.we    = we;
      r.addr  = addr;
      r.wdata = wdata;
      cnt     = 0;
      if (timeouts == 0) begin
         m_req[m]       <= r;
         m_req_valid[m] <= 1'b1;
         do begin
            @(posedge clk);
            cnt++;
         end while (!m_req_ready[m] && cnt < req_limit && timeouts == 0);
         if (!m_req_ready[m] && timeouts == 0) begin
            $display("timeout: master %0d request was never accepted, at %0t", m, $time);
            timeouts++;
         end
         m_req_valid[m] <= 1'b0;
      end
   endtask

   task automatic run_random(input int m, input int count, input logic [31:0] seed);
      logic [31:0] s;
      logic [mem_bus_pkg::addr_w-1:0] addr;
      s = seed;
      for (int i = 0; i < count; i++) begin
         s    = lcg_step(s);
         addr = mem_bus_pkg::addr_w'(m * half + int'(s[23:8]) % half);  // Own half only
         s    = lcg_step(s);
         send_req(m, s[13], addr, s);
      end
   endtask

   task automatic read_range(input int m, input int lo, input int hi);
      for (int a = lo; a < hi; a++)
         send_req(m, 1'b0, mem_bus_pkg::addr_w'(a), '0);
   endtask

   task automatic write_read(input int m);
      logic [mem_bus_pkg::addr_w-1:0] addr;
      rng  = lcg_step(rng);
      addr = mem_bus_pkg::addr_w'(m * half + int'(rng[23:8]) % half);
      rng  = lcg_step(rng);
      send_req(m, 1'b1, addr, rng);
      send_req(m, 1'b0, addr, '0);
   endtask

   task automatic wait_drain();
      int cnt;
      cnt = 0;
      do begin
         @(posedge clk);
         cnt++;
      end while ((exp_q[0].size() != 0 || exp_q[1].size() != 0) && cnt < drain_limit
                 && timeouts == 0);
      if (timeouts == 0 && (exp_q[0].size() != 0 || exp_q[1].size() != 0)) begin
         $display("timeout: responses still missing at %0t (%0d and %0d)",
                  $time, exp_q[0].size(), exp_q[1].size());
         timeouts++;
      end
   endtask

   // ----------------------------------------------------------
   // Sequence
   // ----------------------------------------------------------

   initial begin
      arst_n      = 1'b0;
      m_req       = '0;
      m_req_valid = '0;
      m_rsp_ready = '1;
      rng         = 32'd88;
      for (int a = 0; a < mem_bus_pkg::mem_depth; a++)
         ref_mem[a] = '0;

      repeat (3) @(posedge clk);
      arst_n <= 1'b1;
      if (m_rsp_valid !== '0) begin
         $display("ERROR %0t m_rsp_valid expected %b actual %b", $time, 2'b00, m_rsp_valid);
         errors++;
      end

      // Ready must stay low through init and the reset synchronizer
      n = 0;
      while (m_req_ready == '0 && n < init_limit) begin
         @(posedge clk);
         n++;
      end
      if (n - 1 < min_release) begin
         $display("m_req_ready rose %0d cycles after reset release, expected at least %0d",
                  n - 1, min_release);
         errors++;
      end
      while (m_req_ready != '1 && n < init_limit) begin
         @(posedge clk);
         n++;
      end
      if (m_req_ready != '1) begin
         $display("timeout: both m_req_ready never went high after reset");
         timeouts++;
      end

      write_read(0);
      wait_drain();
      write_read(1);
      wait_drain();

      // Both masters at once on disjoint halves
      fork
         run_random(0, 24, 32'd88 ^ rng);
         run_random(1, 24, ~rng);
      join
      wait_drain();

      // Out-of-range accesses and then a full sweep of the array
      send_req(0, 1'b1, mem_bus_pkg::addr_w'(mem_bus_pkg::mem_depth + 5), 32'hdead_beef);
      send_req(1, 1'b0, '1, '0);
      wait_drain();
      fork
         read_range(0, 0, half);
         read_range(1, half, mem_bus_pkg::mem_depth);
      join
      wait_drain();

      // Back-pressure on master 0
      rng = lcg_step(rng);
      stall = 20 + int'(rng[15:0]) % 30;
      m_rsp_ready[0] <= 1'b0;
      fork
         run_random(0, 5, rng);
         run_random(1, 4, lcg_step(rng));
         begin
            repeat (stall) @(posedge clk);
            m_rsp_ready[0] <= 1'b1;
         end
      join
      run_random(1, 6, rng ^ 32'h5a5a_5a5a);
      wait_drain();

      $display("errors %0d, timeouts %0d, responses checked %0d", errors, timeouts, rsp_count);
      if (errors == 0 && timeouts == 0) begin
         $display("test passed");
      end else begin
         $display("test failed");
      end
      $finish;
   end

endmodule

// File: flist.f
common/mem_bus_pkg.sv
common/system_pkg.sv
logic/reset_sync.sv
memory/mem_init_timer.sv
memory/mem_model.sv
logic/pipe_reg.sv
logic/bus_arbiter.sv
logic/top_system.sv
bench/tb_top_system.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_top_system
FLIST     := flist.f
OBJ_DIR   := obj_dir
BIN       := $(OBJ_DIR)/V$(TOP)
SRCS      := $(filter-out +%,$(shell cat $(FLIST)))

.PHONY: all run clean

all: $(BIN)

# Rebuilt only when a source or the file list changes
$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)

run: $(BIN)
	@out="$$(./$(BIN))"; echo "$$out"; echo "$$out" | grep -qx "test passed"

clean:
	rm -rf $(OBJ_DIR)
